// File: rtl/nic_pkg.sv
package nic_pkg;

	// EEPROM geometry, 256 words of 16 bits
	localparam int EE_ADDR_W = 8;
	localparam int EE_DATA_W = 16;

	// Host register port
	localparam int REG_ADDR_W = 4;
	localparam int REG_DATA_W = 32;

	// Reset sequencer counter, top bit ends the reset
	localparam int RST_CNT_W = 7;

	// Sum of words 0x00..0x3F must give this
	localparam logic [EE_DATA_W-1:0] EE_CHECKSUM = 16'hBABA;
	localparam logic [EE_ADDR_W-1:0] EE_CHECKSUM_ADDR = 8'h3F;

	// Register field positions
	localparam int CTRL_RST_BIT = 0;
	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_DONE_BIT = 1;
	localparam int EERD_START_BIT = 0;
	localparam int EERD_DONE_BIT = 4;
	localparam int EERD_ADDR_LSB = 8;
	localparam int EERD_DATA_LSB = 16;

	// Host register map
	typedef enum logic [REG_ADDR_W-1:0] {
		REG_CTRL    = 4'd0,
		REG_STATUS  = 4'd1,
		REG_EERD    = 4'd2,
		REG_SCRATCH = 4'd3
	} reg_addr_e;

	// Microwire opcodes, sent after the start bit
	typedef enum logic [1:0] {
		MW_EWEN  = 2'b00,
		MW_WRITE = 2'b01,
		MW_READ  = 2'b10,
		MW_ERASE = 2'b11
	} mw_opcode_e;

	typedef enum logic [1:0] {CTRL_IDLE, CTRL_ACCESS, CTRL_ACK, CTRL_RELEASE} ctrl_state_e;
	typedef enum logic [1:0] {MW_IDLE, MW_SHIFT, MW_DONE} mw_state_e;
	typedef enum logic [1:0] {EMU_CMD, EMU_LOAD, EMU_DATA, EMU_WAIT} emu_state_e;

endpackage

// File: rtl/nic_reset_sync.sv
module nic_reset_sync (
	input  logic nic_clk,
	input  logic ext_rst,
	input  logic clk_locked_i,
	input  logic reset_request_i,
	output logic nic_rst_o
);
	import nic_pkg::*;

	logic [RST_CNT_W-1:0] rst_cnt;

	// Count locked cycles, stop once the top bit sets
	always_ff @(posedge nic_clk or posedge ext_rst) begin
		if (ext_rst) begin
			rst_cnt <= '0;
		end else if (reset_request_i || !clk_locked_i) begin
			// Software reset or lost lock restarts the wait
			rst_cnt <= '0;
		end else if (!rst_cnt[RST_CNT_W-1]) begin
			rst_cnt <= rst_cnt + 1'b1;
		end
	end

	// Held in reset until 64 clean cycles have passed
	assign nic_rst_o = !rst_cnt[RST_CNT_W-1];

endmodule

// File: rtl/config_rom.sv
module config_rom #(
	parameter logic [47:0] MAC_ADDR = 48'h02_00_00_00_00_01
) (
	input  logic                          nic_clk,
	input  logic                          nic_rst_i,
	input  logic                          rom_ren_i,
	input  logic [nic_pkg::EE_ADDR_W-1:0] rom_addr_i,
	output logic [nic_pkg::EE_DATA_W-1:0] rom_data_o
);
	import nic_pkg::*;

	// Byte 0 of the MAC is the top byte of MAC_ADDR, low half of word 0
	localparam logic [EE_DATA_W-1:0] MAC_WORD0 = {MAC_ADDR[39:32], MAC_ADDR[47:40]};
	localparam logic [EE_DATA_W-1:0] MAC_WORD1 = {MAC_ADDR[23:16], MAC_ADDR[31:24]};
	localparam logic [EE_DATA_W-1:0] MAC_WORD2 = {MAC_ADDR[7:0], MAC_ADDR[15:8]};
	// Makes words 0x00..0x3F add up to the checksum, modulo 2^16
	localparam logic [EE_DATA_W-1:0] CSUM_WORD =
		EE_CHECKSUM - (MAC_WORD0 + MAC_WORD1 + MAC_WORD2);

	// One cycle lookup, rest of the array reads 0
	always_ff @(posedge nic_clk or posedge nic_rst_i) begin
		if (nic_rst_i) begin
			rom_data_o <= '0;
		end else if (rom_ren_i) begin
			case (rom_addr_i)
				EE_ADDR_W'(0): rom_data_o <= MAC_WORD0;
				EE_ADDR_W'(1): rom_data_o <= MAC_WORD1;
				EE_ADDR_W'(2): rom_data_o <= MAC_WORD2;
				EE_CHECKSUM_ADDR: rom_data_o <= CSUM_WORD;
				default: rom_data_o <= '0;
			endcase
		end
	end

endmodule

// File: rtl/eeprom_emu.sv
module eeprom_emu (
	input  logic                          nic_clk,
	input  logic                          nic_rst_i,
	input  logic                          ee_cs_i,
	input  logic                          ee_sk_i,
	input  logic                          ee_di_i,
	output logic                          ee_do_o,
	output logic                          rom_ren_o,
	output logic [nic_pkg::EE_ADDR_W-1:0] rom_addr_o,
	input  logic [nic_pkg::EE_DATA_W-1:0] rom_data_i
);
	import nic_pkg::*;

	localparam int CMD_BITS = 3 + EE_ADDR_W;
	// Count value on the rise after the last data bit
	localparam int LAST_BIT = CMD_BITS + EE_DATA_W;
	localparam int CNT_W = $clog2(LAST_BIT + 1);

	emu_state_e           state;
	logic                 sk_q;
	logic                 sk_rise;
	logic [CNT_W-1:0]     bit_cnt;
	// Opcode and upper address bits, start bit not kept
	logic [CMD_BITS-3:0]  cmd_sr;
	logic [EE_DATA_W-1:0] data_sr;
	mw_opcode_e           opcode;
	logic                 cmd_last;

	assign sk_rise = ee_sk_i && !sk_q;
	assign opcode = mw_opcode_e'(cmd_sr[CMD_BITS-3 -: 2]);
	// Address LSB is still on di in this cycle
	assign cmd_last = (state == EMU_CMD) && ee_cs_i && sk_rise &&
		(bit_cnt == CNT_W'(CMD_BITS - 1));

	// ROM fetch fires on the last command bit of a READ
	assign rom_ren_o = cmd_last && (opcode == MW_READ);
	assign rom_addr_o = {cmd_sr[EE_ADDR_W-2:0], ee_di_i};

	always_ff @(posedge nic_clk or posedge nic_rst_i) begin
		if (nic_rst_i) begin
			state <= EMU_CMD;
			sk_q <= 1'b0;
			bit_cnt <= '0;
			ee_do_o <= 1'b1;
		end else begin
			sk_q <= ee_sk_i;
			if (!ee_cs_i) begin
				// Deselect aborts anything in progress
				state <= EMU_CMD;
				bit_cnt <= '0;
				ee_do_o <= 1'b1;
			end else begin
				case (state)
					// Leading zeros before the start bit are skipped
					EMU_CMD: if (sk_rise && ((bit_cnt != '0) || ee_di_i)) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (cmd_last) begin
							case (opcode)
								MW_READ: begin
									state <= EMU_LOAD;
									ee_do_o <= 1'b0;
								end
								// Accepted but nothing is written
								MW_EWEN, MW_WRITE, MW_ERASE: state <= EMU_WAIT;
							endcase
						end
					end
					EMU_LOAD: state <= EMU_DATA;
					EMU_DATA: if (sk_rise) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == CNT_W'(LAST_BIT)) begin
							state <= EMU_WAIT;
							ee_do_o <= 1'b1;
						end else begin
							ee_do_o <= data_sr[EE_DATA_W-1];
						end
					end
					// Idle high until cs drops
					EMU_WAIT: ee_do_o <= 1'b1;
				endcase
			end
		end
	end

	// Command bits after the start bit
	always_ff @(posedge nic_clk) begin
		if ((state == EMU_CMD) && ee_cs_i && sk_rise && (bit_cnt != '0)) begin
			cmd_sr <= {cmd_sr[CMD_BITS-4:0], ee_di_i};
		end
	end

	// ROM word in, then MSB first out
	always_ff @(posedge nic_clk) begin
		if (state == EMU_LOAD) begin
			data_sr <= rom_data_i;
		end else if ((state == EMU_DATA) && sk_rise) begin
			data_sr <= {data_sr[EE_DATA_W-2:0], 1'b0};
		end
	end

endmodule

// File: rtl/microwire_master.sv
module microwire_master #(
	parameter int SK_HALF_CYCLES = 2
) (
	input  logic                          nic_clk,
	input  logic                          nic_rst_i,
	input  logic                          mw_req_i,
	input  logic [nic_pkg::EE_ADDR_W-1:0] mw_addr_i,
	output logic                          mw_ack_o,
	output logic [nic_pkg::EE_DATA_W-1:0] mw_data_o,
	output logic                          ee_cs_o,
	output logic                          ee_sk_o,
	output logic                          ee_di_o,
	input  logic                          ee_do_i
);
	import nic_pkg::*;

	// Start bit, opcode, address
	localparam int CMD_BITS = 3 + EE_ADDR_W;
	// Command, dummy zero, then the data word
	localparam int TOTAL_RISES = CMD_BITS + 1 + EE_DATA_W;
	localparam int RISE_W = $clog2(TOTAL_RISES + 1);
	localparam int DIV_W = $clog2(SK_HALF_CYCLES + 1);

	mw_state_e            state;
	logic [DIV_W-1:0]     div_cnt;
	logic                 half_tick;
	logic [RISE_W-1:0]    rise_cnt;
	logic [CMD_BITS-1:0]  cmd_sr;
	logic [EE_DATA_W-1:0] data_sr;

	// End of each serial clock half period
	assign half_tick = (state == MW_SHIFT) && (div_cnt == DIV_W'(SK_HALF_CYCLES - 1));

	assign ee_di_o = cmd_sr[CMD_BITS-1];
	assign mw_ack_o = (state == MW_DONE);
	assign mw_data_o = data_sr;

	always_ff @(posedge nic_clk or posedge nic_rst_i) begin
		if (nic_rst_i) begin
			state <= MW_IDLE;
			div_cnt <= '0;
			rise_cnt <= '0;
			cmd_sr <= '0;
			ee_cs_o <= 1'b0;
			ee_sk_o <= 1'b0;
		end else begin
			case (state)
				MW_IDLE: if (mw_req_i) begin
					// Start bit is on di as cs rises
					state <= MW_SHIFT;
					ee_cs_o <= 1'b1;
					div_cnt <= '0;
					rise_cnt <= '0;
					cmd_sr <= {1'b1, MW_READ, mw_addr_i};
				end
				MW_SHIFT: begin
					div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
					if (half_tick && !ee_sk_o) begin
						ee_sk_o <= 1'b1;
						rise_cnt <= rise_cnt + 1'b1;
					end else if (half_tick) begin
						// Next command bit goes out on the falling edge
						ee_sk_o <= 1'b0;
						cmd_sr <= {cmd_sr[CMD_BITS-2:0], 1'b0};
						if (rise_cnt == RISE_W'(TOTAL_RISES)) begin
							state <= MW_DONE;
							ee_cs_o <= 1'b0;
						end
					end
				end
				// Hold ack until the requester lets go
				MW_DONE: if (!mw_req_i) state <= MW_IDLE;
				default: state <= MW_IDLE;
			endcase
		end
	end

	// Sample do as sk rises, past the command and the dummy bit
	always_ff @(posedge nic_clk) begin
		if (half_tick && !ee_sk_o && (rise_cnt > RISE_W'(CMD_BITS))) begin
			data_sr <= {data_sr[EE_DATA_W-2:0], ee_do_i};
		end
	end

endmodule

// File: rtl/host_reg_ctrl.sv
module host_reg_ctrl (
	input  logic                            nic_clk,
	input  logic                            nic_rst_i,
	input  logic                            host_req_i,
	input  logic                            host_we_i,
	input  logic [nic_pkg::REG_ADDR_W-1:0]  host_addr_i,
	input  logic [nic_pkg::REG_DATA_W-1:0]  host_wdata_i,
	output logic                            host_ack_o,
	output logic [nic_pkg::REG_DATA_W-1:0]  host_rdata_o,
	output logic                            reset_request_o,
	output logic                            mw_req_o,
	output logic [nic_pkg::EE_ADDR_W-1:0]   mw_addr_o,
	input  logic                            mw_ack_i,
	input  logic [nic_pkg::EE_DATA_W-1:0]   mw_data_i
);
	import nic_pkg::*;

	ctrl_state_e           state;
	reg_addr_e             reg_addr;
	logic [REG_DATA_W-1:0] scratch;
	logic [REG_DATA_W-1:0] rdata_mux;
	logic [EE_ADDR_W-1:0]  eerd_addr;
	logic [EE_DATA_W-1:0]  eerd_data;
	logic                  ee_busy;
	logic                  ee_done;
	logic                  rst_pend;
	logic                  wr_strobe;
	logic                  start_strobe;

	assign reg_addr = reg_addr_e'(host_addr_i);

	// Writes take effect in the single access cycle
	assign wr_strobe = (state == CTRL_ACCESS) && host_we_i;
	// START while a read is in flight is dropped
	assign start_strobe = wr_strobe && (reg_addr == REG_EERD) &&
		host_wdata_i[EERD_START_BIT] && !ee_busy;

	// Host handshake FSM
	always_ff @(posedge nic_clk or posedge nic_rst_i) begin
		if (nic_rst_i) begin
			state <= CTRL_IDLE;
		end else begin
			case (state)
				CTRL_IDLE: if (host_req_i) state <= CTRL_ACCESS;
				CTRL_ACCESS: state <= CTRL_ACK;
				// Ack stays up as long as the host holds req
				CTRL_ACK: if (!host_req_i) state <= CTRL_RELEASE;
				CTRL_RELEASE: state <= CTRL_IDLE;
				default: state <= CTRL_IDLE;
			endcase
		end
	end

	assign host_ack_o = (state == CTRL_ACK);
	// Device reset only once the handshake has closed
	assign reset_request_o = (state == CTRL_RELEASE) && rst_pend;

	// Read decode, unmapped addresses give 0
	// CTRL reads 0 as RST clears itself before any read
	always_comb begin
		rdata_mux = '0;
		case (reg_addr)
			REG_STATUS: begin
				rdata_mux[STATUS_BUSY_BIT] = ee_busy;
				rdata_mux[STATUS_DONE_BIT] = ee_done;
			end
			REG_EERD: begin
				rdata_mux[EERD_DATA_LSB +: EE_DATA_W] = eerd_data;
				rdata_mux[EERD_ADDR_LSB +: EE_ADDR_W] = eerd_addr;
				rdata_mux[EERD_DONE_BIT] = ee_done;
			end
			REG_SCRATCH: rdata_mux = scratch;
			default: rdata_mux = '0;
		endcase
	end

	// Read data captured once per access
	always_ff @(posedge nic_clk) begin
		if (state == CTRL_ACCESS) begin
			host_rdata_o <= rdata_mux;
		end
	end

	// Scratch and pending software reset
	always_ff @(posedge nic_clk or posedge nic_rst_i) begin
		if (nic_rst_i) begin
			scratch <= '0;
			rst_pend <= 1'b0;
		end else begin
			if (wr_strobe && (reg_addr == REG_SCRATCH)) begin
				scratch <= host_wdata_i;
			end
			if (wr_strobe && (reg_addr == REG_CTRL)) begin
				rst_pend <= host_wdata_i[CTRL_RST_BIT];
			end else if (state == CTRL_RELEASE) begin
				rst_pend <= 1'b0;
			end
		end
	end

	// EERD fields and request side of the serial read
	always_ff @(posedge nic_clk or posedge nic_rst_i) begin
		if (nic_rst_i) begin
			eerd_addr <= '0;
			eerd_data <= '0;
			ee_busy <= 1'b0;
			ee_done <= 1'b0;
			mw_req_o <= 1'b0;
		end else if (start_strobe) begin
			eerd_addr <= host_wdata_i[EERD_ADDR_LSB +: EE_ADDR_W];
			ee_done <= 1'b0;
			ee_busy <= 1'b1;
			mw_req_o <= 1'b1;
		end else if (mw_req_o && mw_ack_i) begin
			// Word is in, release the master
			eerd_data <= mw_data_i;
			ee_busy <= 1'b0;
			ee_done <= 1'b1;
			mw_req_o <= 1'b0;
		end
	end

	assign mw_addr_o = eerd_addr;

endmodule

// File: rtl/nic_core_top.sv
module nic_core_top #(
	parameter logic [47:0] MAC_ADDR = 48'h02_00_00_00_00_01,
	parameter int SK_HALF_CYCLES = 2
) (
	input  logic                           nic_clk,
	input  logic                           ext_rst,
	input  logic                           clk_locked_i,
	input  logic                           host_req_i,
	input  logic                           host_we_i,
	input  logic [nic_pkg::REG_ADDR_W-1:0] host_addr_i,
	input  logic [nic_pkg::REG_DATA_W-1:0] host_wdata_i,
	output logic                           host_ack_o,
	output logic [nic_pkg::REG_DATA_W-1:0] host_rdata_o,
	output logic                           nic_rst_o
);
	import nic_pkg::*;

	logic                 reset_request;
	// EEPROM read request
	logic                 mw_req;
	logic [EE_ADDR_W-1:0] mw_addr;
	logic                 mw_ack;
	logic [EE_DATA_W-1:0] mw_data;
	// Microwire bus, kept on chip
	logic                 ee_cs;
	logic                 ee_sk;
	logic                 ee_di;
	logic                 ee_do;
	// ROM port
	logic                 rom_ren;
	logic [EE_ADDR_W-1:0] rom_addr;
	logic [EE_DATA_W-1:0] rom_data;

	nic_reset_sync reset_sync_i (
		.nic_clk(nic_clk),
		.ext_rst(ext_rst),
		.clk_locked_i(clk_locked_i),
		.reset_request_i(reset_request),
		.nic_rst_o(nic_rst_o)
	);

	// Register path sits in the NIC reset domain
	host_reg_ctrl host_reg_ctrl_i (
		.nic_clk(nic_clk),
		.nic_rst_i(nic_rst_o),
		.host_req_i(host_req_i),
		.host_we_i(host_we_i),
		.host_addr_i(host_addr_i),
		.host_wdata_i(host_wdata_i),
		.host_ack_o(host_ack_o),
		.host_rdata_o(host_rdata_o),
		.reset_request_o(reset_request),
		.mw_req_o(mw_req),
		.mw_addr_o(mw_addr),
		.mw_ack_i(mw_ack),
		.mw_data_i(mw_data)
	);

	microwire_master #(
		.SK_HALF_CYCLES(SK_HALF_CYCLES)
	) microwire_master_i (
		.nic_clk(nic_clk),
		.nic_rst_i(nic_rst_o),
		.mw_req_i(mw_req),
		.mw_addr_i(mw_addr),
		.mw_ack_o(mw_ack),
		.mw_data_o(mw_data),
		.ee_cs_o(ee_cs),
		.ee_sk_o(ee_sk),
		.ee_di_o(ee_di),
		.ee_do_i(ee_do)
	);

	eeprom_emu eeprom_emu_i (
		.nic_clk(nic_clk),
		.nic_rst_i(nic_rst_o),
		.ee_cs_i(ee_cs),
		.ee_sk_i(ee_sk),
		.ee_di_i(ee_di),
		.ee_do_o(ee_do),
		.rom_ren_o(rom_ren),
		.rom_addr_o(rom_addr),
		.rom_data_i(rom_data)
	);

	config_rom #(
		.MAC_ADDR(MAC_ADDR)
	) rom_i (
		.nic_clk(nic_clk),
		.nic_rst_i(nic_rst_o),
		.rom_ren_i(rom_ren),
		.rom_addr_i(rom_addr),
		.rom_data_o(rom_data)
	);

endmodule

// File: verification/nic_core_tb.sv
module nic_core_tb;
	import nic_pkg::*;

	localparam logic [47:0] MAC_ADDR = 48'hA4_5E_60_C1_72_39;
	localparam int SK_HALF_CYCLES = 2;
	// Cycle limits for each kind of wait
	localparam int ACK_TIMEOUT = 20;
	localparam int RST_TIMEOUT = 200;
	localparam int POLL_LIMIT = 100;

	logic                  nic_clk;
	logic                  ext_rst;
	logic                  clk_locked_i;
	logic                  host_req_i;
	logic                  host_we_i;
	logic [REG_ADDR_W-1:0] host_addr_i;
	logic [REG_DATA_W-1:0] host_wdata_i;
	logic                  host_ack_o;
	logic [REG_DATA_W-1:0] host_rdata_o;
	logic                  nic_rst_o;

	// Checks waiting for the compare process
	string       chk_name_q[$];
	logic [31:0] chk_got_q[$];
	logic [31:0] chk_exp_q[$];
	int          check_count = 0;
	int          err_count = 0;
	int          timeout_count = 0;
	logic [31:0] rng_state;

	nic_core_top #(
		.MAC_ADDR(MAC_ADDR),
		.SK_HALF_CYCLES(SK_HALF_CYCLES)
	) dut_i (
		.nic_clk(nic_clk),
		.ext_rst(ext_rst),
		.clk_locked_i(clk_locked_i),
		.host_req_i(host_req_i),
		.host_we_i(host_we_i),
		.host_addr_i(host_addr_i),
		.host_wdata_i(host_wdata_i),
		.host_ack_o(host_ack_o),
		.host_rdata_o(host_rdata_o),
		.nic_rst_o(nic_rst_o)
	);

	initial begin
		nic_clk = 1'b0;
		forever #50 nic_clk = ~nic_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// MAC byte k, byte 0 is the most significant
	function automatic logic [7:0] mac_byte(input int k);
		return 8'(MAC_ADDR >> (8 * (5 - k)));
	endfunction

	// Expected EEPROM word at addr
	function automatic logic [15:0] ee_word(input logic [7:0] addr);
		logic [15:0] w0;
		logic [15:0] w1;
		logic [15:0] w2;
		// Even byte in the low half of each word
		w0 = {mac_byte(1), mac_byte(0)};
		w1 = {mac_byte(3), mac_byte(2)};
		w2 = {mac_byte(5), mac_byte(4)};
		case (addr)
			8'h00: return w0;
			8'h01: return w1;
			8'h02: return w2;
			// Balances words 0x00..0x3F to 0xBABA
			8'h3F: return 16'hBABA - w0 - w1 - w2;
			default: return 16'h0000;
		endcase
	endfunction

	function automatic void push_check(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		chk_name_q.push_back(name);
		chk_got_q.push_back(got);
		chk_exp_q.push_back(exp);
	endfunction

	// Compare process, drains pending checks on each rising edge
	initial begin
		string       name;
		logic [31:0] got;
		logic [31:0] exp;
		forever begin
			@(posedge nic_clk);
			while (chk_got_q.size() > 0) begin
				name = chk_name_q.pop_front();
				got = chk_got_q.pop_front();
				exp = chk_exp_q.pop_front();
				check_count++;
				if (got !== exp) begin
					err_count++;
					$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
				end
			end
		end
	end

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (host_ack_o !== level && n < ACK_TIMEOUT) begin
			@(negedge nic_clk);
			n++;
		end
		if (host_ack_o !== level) begin
			timeout_count++;
			$display("Timeout at t=%0t: host_ack_o never went to %0b", $time, level);
		end
	endtask

	// Drive a request and leave it held
	task automatic raise_request(input logic we, input logic [REG_ADDR_W-1:0] addr,
		input logic [31:0] wdata);
		host_req_i = 1'b1;
		host_we_i = we;
		host_addr_i = addr;
		host_wdata_i = wdata;
	endtask

	// Wait for ack, take the read data and close the handshake
	task automatic complete_access(output logic [31:0] rdata);
		wait_ack(1'b1);
		rdata = host_rdata_o;
		host_req_i = 1'b0;
		wait_ack(1'b0);
	endtask

	// One four-phase host access
	task automatic host_access(input logic we, input logic [REG_ADDR_W-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		@(negedge nic_clk);
		raise_request(we, addr, wdata);
		complete_access(rdata);
	endtask

	task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		host_access(1'b1, addr, wdata, unused);
	endtask

	task automatic reg_read(input logic [REG_ADDR_W-1:0] addr, output logic [31:0] rdata);
		host_access(1'b0, addr, 32'h0, rdata);
	endtask

	// Poll EERD until DONE (bit 4)
	task automatic poll_eerd(output logic [31:0] r);
		int polls;
		polls = 0;
		reg_read(REG_EERD, r);
		while (!r[4] && polls < POLL_LIMIT) begin
			reg_read(REG_EERD, r);
			polls++;
		end
		if (!r[4]) begin
			timeout_count++;
			$display("Timeout at t=%0t: EERD DONE never set", $time);
		end
	endtask

	task automatic eerd_read(input logic [7:0] addr, output logic [15:0] data);
		logic [31:0] r;
		// START in bit 0, address in 15:8
		reg_write(REG_EERD, {16'h0000, addr, 7'h00, 1'b1});
		poll_eerd(r);
		push_check("host_rdata_o[15:8]", {24'h0, r[15:8]}, {24'h0, addr});
		data = r[31:16];
	endtask

	task automatic wait_rst_rise();
		int n;
		n = 0;
		while (!nic_rst_o && n < ACK_TIMEOUT) begin
			@(negedge nic_clk);
			n++;
		end
		if (!nic_rst_o) begin
			timeout_count++;
			$display("Timeout at t=%0t: nic_rst_o never rose", $time);
		end
	endtask

	// Counts rising edges until the NIC reset drops
	task automatic wait_rst_fall(output int cycles);
		int ack_cycles;
		cycles = 0;
		ack_cycles = 0;
		while (nic_rst_o && cycles < RST_TIMEOUT) begin
			@(negedge nic_clk);
			cycles++;
			if (host_ack_o) ack_cycles++;
		end
		if (nic_rst_o) begin
			timeout_count++;
			$display("Timeout at t=%0t: nic_rst_o never fell", $time);
		end
		push_check("host_ack_o high cycles", ack_cycles, 32'd0);
	endtask

	task automatic report_test(input string name, input int chk_start, input int err_start);
		// One more edge so the compare process is empty
		@(negedge nic_clk);
		$display("%s: %0d checks, %0d errors", name, check_count - chk_start,
			err_count + timeout_count - err_start);
	endtask

	initial begin
		int          cycles;
		int          chk0;
		int          err0;
		int          i;
		logic [31:0] rd;
		logic [31:0] val;
		logic [15:0] word;
		logic [15:0] sum;
		logic [7:0]  addr;

		ext_rst = 1'b1;
		clk_locked_i = 1'b1;
		host_req_i = 1'b0;
		host_we_i = 1'b0;
		host_addr_i = '0;
		host_wdata_i = '0;
		rng_state = 32'he708;

		// Reset release and lock loss
		chk0 = check_count;
		err0 = err_count + timeout_count;
		repeat (3) @(negedge nic_clk);
		push_check("nic_rst_o", {31'h0, nic_rst_o}, 32'd1);
		ext_rst = 1'b0;
		// Scratch read held up by the NIC reset
		raise_request(1'b0, REG_SCRATCH, 32'h0);
		wait_rst_fall(cycles);
		push_check("nic_rst_o cycles after ext_rst", cycles, 32'd64);
		complete_access(rd);
		push_check("host_rdata_o scratch", rd, 32'd0);
		@(negedge nic_clk);
		clk_locked_i = 1'b0;
		repeat (5) @(negedge nic_clk);
		push_check("nic_rst_o", {31'h0, nic_rst_o}, 32'd1);
		clk_locked_i = 1'b1;
		raise_request(1'b0, REG_EERD, 32'h0);
		wait_rst_fall(cycles);
		push_check("nic_rst_o cycles after lock", cycles, 32'd64);
		complete_access(rd);
		push_check("host_rdata_o eerd", rd, 32'd0);
		report_test("reset_sequencing", chk0, err0);

		// Scratch and unmapped space
		chk0 = check_count;
		err0 = err_count + timeout_count;
		val = '0;
		for (i = 0; i < 8; i++) begin
			rng_state = xorshift32(rng_state);
			val = rng_state;
			reg_write(REG_SCRATCH, val);
			reg_read(REG_SCRATCH, rd);
			push_check("host_rdata_o scratch", rd, val);
		end
		rng_state = xorshift32(rng_state);
		reg_write(4'hA, rng_state);
		reg_read(4'hA, rd);
		push_check("host_rdata_o unmapped", rd, 32'd0);
		reg_read(REG_SCRATCH, rd);
		push_check("host_rdata_o scratch", rd, val);
		report_test("register_access", chk0, err0);

		// MAC words
		chk0 = check_count;
		err0 = err_count + timeout_count;
		for (i = 0; i < 3; i++) begin
			eerd_read(8'(i), word);
			push_check("host_rdata_o[31:16] mac", {16'h0, word}, {16'h0, ee_word(8'(i))});
		end
		report_test("mac_words", chk0, err0);

		// Random words, then the checksum region
		chk0 = check_count;
		err0 = err_count + timeout_count;
		for (i = 0; i < 40; i++) begin
			rng_state = xorshift32(rng_state);
			addr = rng_state[7:0];
			eerd_read(addr, word);
			push_check("host_rdata_o[31:16]", {16'h0, word}, {16'h0, ee_word(addr)});
		end
		sum = '0;
		for (i = 0; i < 64; i++) begin
			eerd_read(8'(i), word);
			sum = sum + word;
		end
		push_check("eeprom checksum", {16'h0, sum}, 32'h0000BABA);
		report_test("eeprom_contents", chk0, err0);

		// Second START while busy is dropped
		chk0 = check_count;
		err0 = err_count + timeout_count;
		reg_write(REG_EERD, {16'h0000, 8'h02, 7'h00, 1'b1});
		reg_read(REG_STATUS, rd);
		push_check("host_rdata_o[0] busy", {31'h0, rd[0]}, 32'd1);
		reg_write(REG_EERD, {16'h0000, 8'h3F, 7'h00, 1'b1});
		poll_eerd(rd);
		push_check("host_rdata_o[15:8]", {24'h0, rd[15:8]}, 32'h00000002);
		push_check("host_rdata_o[31:16]", {16'h0, rd[31:16]}, {16'h0, ee_word(8'h02)});
		reg_read(REG_STATUS, rd);
		push_check("host_rdata_o[1:0] status", {30'h0, rd[1:0]}, 32'd2);
		report_test("busy_rule", chk0, err0);

		// Software reset clears the register block
		chk0 = check_count;
		err0 = err_count + timeout_count;
		reg_write(REG_SCRATCH, 32'h5A5A_0F0F);
		eerd_read(8'h01, word);
		reg_write(REG_CTRL, 32'h0000_0001);
		wait_rst_rise();
		// Scratch read waits out the software reset
		raise_request(1'b0, REG_SCRATCH, 32'h0);
		wait_rst_fall(cycles);
		push_check("nic_rst_o cycles after soft reset", cycles, 32'd64);
		complete_access(rd);
		push_check("host_rdata_o scratch", rd, 32'd0);
		reg_read(REG_EERD, rd);
		push_check("host_rdata_o eerd", rd, 32'd0);
		report_test("software_reset", chk0, err0);

		@(negedge nic_clk);
		$display("Total: %0d checks, %0d errors, %0d timeouts", check_count, err_count,
			timeout_count);
		if (err_count + timeout_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: sources.f
rtl/nic_pkg.sv
rtl/nic_reset_sync.sv
rtl/config_rom.sv
rtl/eeprom_emu.sv
rtl/microwire_master.sv
rtl/host_reg_ctrl.sv
rtl/nic_core_top.sv
verification/nic_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = nic_core_tb
FILELIST  = sources.f
OBJDIR    = obj_dir
PASS_MSG  = Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
